/* common/vec_pkg.sv */
// Shared constants of the vector coprocessor
// Element, index and length types, opcode enum
`default_nettype none

package vec_pkg;

  ////////////////////
  // Machine shape
  ////////////////////

  // Must stay a power of two
  localparam int unsigned NrLanes      = 4;
  localparam int unsigned Vlen         = 256;
  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned Vlmax        = Vlen / ElemWidth;
  localparam int unsigned ElemsPerLane = Vlmax / NrLanes;
  localparam int unsigned NrVRegs      = 8;

  // Derived widths
  localparam int unsigned VRegIdxWidth = $clog2(NrVRegs);
  localparam int unsigned VlWidth      = $clog2(Vlmax + 1);
  localparam int unsigned ElemIdxWidth = $clog2(Vlmax);
  localparam int unsigned LaneIdxWidth = (NrLanes > 1) ? $clog2(NrLanes) : 1;
  localparam int unsigned SlotWidth    = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [ElemWidth-1:0]    elem_t;
  typedef logic [VRegIdxWidth-1:0] vreg_idx_t;
  typedef logic [VlWidth-1:0]      vl_t;
  typedef logic [ElemIdxWidth-1:0] elem_idx_t;
  typedef logic [LaneIdxWidth-1:0] lane_idx_t;
  typedef logic [SlotWidth-1:0]    slot_t;

  // Instructions accepted from the scalar core
  typedef enum logic [3:0] {
    VSETVL,
    VADD_VV,
    VSUB_VV,
    VAND_VV,
    VOR_VV,
    VXOR_VV,
    VADD_VX,
    VSUB_VX,
    VAND_VX,
    VOR_VX,
    VXOR_VX,
    // Scalar splat into every element
    VMV_VX,
    // Element at index scalar goes back to the core
    VEXTRACT
  } vec_op_e;

endpackage

`default_nettype wire

/* hw/lane/vec_vrf.sv */
// Lane slice of the vector register file
// Two combinational reads, one clocked write
`timescale 1ns/1ps
`default_nettype none

module vec_vrf (
  input  wire logic          clk_i,
  input  wire logic          arst_n_i,
  input  vec_pkg::vreg_idx_t rd_a_reg_i,
  input  vec_pkg::vreg_idx_t rd_b_reg_i,
  input  vec_pkg::slot_t     rd_slot_i,
  output vec_pkg::elem_t     rd_a_data_o,
  output vec_pkg::elem_t     rd_b_data_o,
  input  wire logic          wr_en_i,
  input  vec_pkg::vreg_idx_t wr_reg_i,
  input  vec_pkg::slot_t     wr_slot_i,
  input  vec_pkg::elem_t     wr_data_i
);

  // Register by slot
  vec_pkg::elem_t mem_q [vec_pkg::NrVRegs][vec_pkg::ElemsPerLane];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
        for (int s = 0; s < vec_pkg::ElemsPerLane; s++) begin
          mem_q[r][s] <= '0;
        end
      end
    end else if (wr_en_i) begin
      mem_q[wr_reg_i][wr_slot_i] <= wr_data_i;
    end
  end

  assign rd_a_data_o = mem_q[rd_a_reg_i][rd_slot_i];
  assign rd_b_data_o = mem_q[rd_b_reg_i][rd_slot_i];

endmodule

`default_nettype wire

/* hw/lane/vec_lane.sv */
// One vector lane
// Slot walker, element ALU and the lane's register slice
`timescale 1ns/1ps
`default_nettype none

module vec_lane #(
  parameter int unsigned LaneId = 0
) (
  input  wire logic          clk_i,
  input  wire logic          arst_n_i,
  input  wire logic          pe_req_valid_i,
  input  vec_pkg::vec_op_e   pe_op_i,
  input  vec_pkg::vreg_idx_t pe_vd_i,
  input  vec_pkg::vreg_idx_t pe_vs1_i,
  input  vec_pkg::vreg_idx_t pe_vs2_i,
  input  vec_pkg::elem_t     pe_scalar_i,
  input  vec_pkg::vl_t       pe_vl_i,
  output logic               lane_done_o,
  output vec_pkg::elem_t     lane_scalar_o
);

  localparam vec_pkg::slot_t LastSlot = vec_pkg::slot_t'(vec_pkg::ElemsPerLane - 1);

  logic               busy_q;
  vec_pkg::slot_t     slot_q;
  vec_pkg::elem_idx_t elem_idx;
  vec_pkg::elem_t     vs2_data;
  vec_pkg::elem_t     vs1_data;
  vec_pkg::elem_t     opb;
  vec_pkg::elem_t     alu_res;
  logic               is_vx;
  logic               is_extract;
  logic               wr_en;

  ////////////////////
  // Slot walker
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      slot_q <= '0;
    end else if (pe_req_valid_i) begin
      busy_q <= 1'b1;
      slot_q <= '0;
    end else if (busy_q) begin
      if (slot_q == LastSlot) begin
        busy_q <= 1'b0;
      end else begin
        slot_q <= slot_q + vec_pkg::slot_t'(1);
      end
    end
  end

  // Pulses while the last slot is being written
  assign lane_done_o = busy_q && (slot_q == LastSlot);

  // Element i sits in lane i mod NrLanes, slot i / NrLanes
  assign elem_idx = vec_pkg::elem_idx_t'(int'(slot_q) * vec_pkg::NrLanes + LaneId);

  ////////////////////
  // Element ALU
  ////////////////////

  assign is_vx = pe_op_i inside {vec_pkg::VADD_VX, vec_pkg::VSUB_VX, vec_pkg::VAND_VX,
                                 vec_pkg::VOR_VX, vec_pkg::VXOR_VX};
  assign opb   = is_vx ? pe_scalar_i : vs1_data;

  always_comb begin
    case (pe_op_i)
      vec_pkg::VADD_VV, vec_pkg::VADD_VX: alu_res = vs2_data + opb;
      vec_pkg::VSUB_VV, vec_pkg::VSUB_VX: alu_res = vs2_data - opb;
      vec_pkg::VAND_VV, vec_pkg::VAND_VX: alu_res = vs2_data & opb;
      vec_pkg::VOR_VV, vec_pkg::VOR_VX:   alu_res = vs2_data | opb;
      vec_pkg::VXOR_VV, vec_pkg::VXOR_VX: alu_res = vs2_data ^ opb;
      vec_pkg::VMV_VX:                    alu_res = pe_scalar_i;
      default:                            alu_res = vs2_data;
    endcase
  end

  // Tail elements keep their old value
  assign is_extract = (pe_op_i == vec_pkg::VEXTRACT);
  assign wr_en      = busy_q && !is_extract && (vec_pkg::vl_t'(elem_idx) < pe_vl_i);

  // Captured only in the lane and slot that own the index
  always_ff @(posedge clk_i) begin
    if (busy_q && is_extract &&
        (elem_idx == vec_pkg::elem_idx_t'(pe_scalar_i))) begin
      lane_scalar_o <= vs2_data;
    end
  end

  vec_vrf i_vrf (
    .clk_i       (clk_i   ),
    .arst_n_i    (arst_n_i),
    .rd_a_reg_i  (pe_vs2_i),
    .rd_b_reg_i  (pe_vs1_i),
    .rd_slot_i   (slot_q  ),
    .rd_a_data_o (vs2_data),
    .rd_b_data_o (vs1_data),
    .wr_en_i     (wr_en   ),
    .wr_reg_i    (pe_vd_i ),
    .wr_slot_i   (slot_q  ),
    .wr_data_i   (alu_res )
  );

endmodule

`default_nettype wire

/* hw/vec_sequencer.sv */
// Backend sequencer
// Broadcasts one instruction to all lanes and collects their completion
// Returns the owning lane's element for VEXTRACT
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer (
  input  wire logic                            clk_i,
  input  wire logic                            arst_n_i,
  // Dispatcher side
  input  wire logic                            seq_req_valid_i,
  output logic                                 seq_req_ready_o,
  input  vec_pkg::vec_op_e                     seq_op_i,
  input  vec_pkg::vreg_idx_t                   seq_vd_i,
  input  vec_pkg::vreg_idx_t                   seq_vs1_i,
  input  vec_pkg::vreg_idx_t                   seq_vs2_i,
  input  vec_pkg::elem_t                       seq_scalar_i,
  input  vec_pkg::vl_t                         seq_vl_i,
  output logic                                 seq_idle_o,
  output logic                                 seq_resp_valid_o,
  output vec_pkg::elem_t                       seq_resp_o,
  // Lane side
  output logic                                 pe_req_valid_o,
  output vec_pkg::vec_op_e                     pe_op_o,
  output vec_pkg::vreg_idx_t                   pe_vd_o,
  output vec_pkg::vreg_idx_t                   pe_vs1_o,
  output vec_pkg::vreg_idx_t                   pe_vs2_o,
  output vec_pkg::elem_t                       pe_scalar_o,
  output vec_pkg::vl_t                         pe_vl_o,
  input  wire logic           [vec_pkg::NrLanes-1:0] lane_done_i,
  input  vec_pkg::elem_t      [vec_pkg::NrLanes-1:0] lane_scalar_i
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT,
    RESP
  } seq_state_e;

  seq_state_e                  state_q;
  seq_state_e                  state_d;
  logic [vec_pkg::NrLanes-1:0] done_q;
  logic [vec_pkg::NrLanes-1:0] done_all;
  vec_pkg::lane_idx_t          ext_lane;

  assign seq_req_ready_o = (state_q == IDLE);
  assign seq_idle_o      = (state_q == IDLE);
  assign pe_req_valid_o  = (state_q == ISSUE);
  assign done_all        = done_q | lane_done_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:  if (seq_req_valid_i) state_d = ISSUE;
      ISSUE: state_d = WAIT;
      WAIT: begin
        if (&done_all) begin
          state_d = (pe_op_o == vec_pkg::VEXTRACT) ? RESP : IDLE;
        end
      end
      RESP:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      done_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ISSUE) begin
        done_q <= '0;
      end else if (state_q == WAIT) begin
        done_q <= done_all;
      end
    end
  end

  // Fields stay put for the whole instruction
  always_ff @(posedge clk_i) begin
    if (seq_req_valid_i && seq_req_ready_o) begin
      pe_op_o     <= seq_op_i;
      pe_vd_o     <= seq_vd_i;
      pe_vs1_o    <= seq_vs1_i;
      pe_vs2_o    <= seq_vs2_i;
      pe_scalar_o <= seq_scalar_i;
      pe_vl_o     <= seq_vl_i;
    end
  end

  // Low index bits name the owning lane
  assign ext_lane         = vec_pkg::lane_idx_t'(pe_scalar_o);
  assign seq_resp_valid_o = (state_q == RESP);
  assign seq_resp_o       = lane_scalar_i[ext_lane];

endmodule

`default_nettype wire

/* hw/vec_dispatcher.sv */
// Request front end toward the scalar core
// Vector length register, VSETVL clamp, one-entry hold toward the sequencer
`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher (
  input  wire logic          clk_i,
  input  wire logic          arst_n_i,
  // Scalar core side
  input  wire logic          acc_req_valid_i,
  output logic               acc_req_ready_o,
  input  vec_pkg::vec_op_e   acc_op_i,
  input  vec_pkg::vreg_idx_t acc_vd_i,
  input  vec_pkg::vreg_idx_t acc_vs1_i,
  input  vec_pkg::vreg_idx_t acc_vs2_i,
  input  vec_pkg::elem_t     acc_scalar_i,
  output logic               acc_resp_valid_o,
  output vec_pkg::elem_t     acc_resp_o,
  // Sequencer side
  output logic               seq_req_valid_o,
  input  wire logic          seq_req_ready_i,
  output vec_pkg::vec_op_e   seq_op_o,
  output vec_pkg::vreg_idx_t seq_vd_o,
  output vec_pkg::vreg_idx_t seq_vs1_o,
  output vec_pkg::vreg_idx_t seq_vs2_o,
  output vec_pkg::elem_t     seq_scalar_o,
  output vec_pkg::vl_t       seq_vl_o,
  input  wire logic          seq_idle_i,
  input  wire logic          seq_resp_valid_i,
  input  vec_pkg::elem_t     seq_resp_i
);

  logic           pend_q;
  logic           setvl_valid_q;
  vec_pkg::elem_t setvl_resp_q;
  vec_pkg::vl_t   vl_q;
  vec_pkg::vl_t   vl_clamp;
  logic           req_fire;
  logic           is_setvl;

  // Nothing held and the backend drained
  assign acc_req_ready_o = !pend_q && seq_idle_i;
  assign req_fire        = acc_req_valid_i && acc_req_ready_o;
  assign is_setvl        = (acc_op_i == vec_pkg::VSETVL);

  // Requested length saturates at Vlmax
  assign vl_clamp = (acc_scalar_i > vec_pkg::elem_t'(vec_pkg::Vlmax)) ?
                    vec_pkg::vl_t'(vec_pkg::Vlmax) : vec_pkg::vl_t'(acc_scalar_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q        <= 1'b0;
      setvl_valid_q <= 1'b0;
      vl_q          <= vec_pkg::vl_t'(vec_pkg::Vlmax);
    end else begin
      setvl_valid_q <= req_fire && is_setvl;
      if (req_fire && is_setvl) begin
        vl_q <= vl_clamp;
      end
      if (req_fire && !is_setvl) begin
        pend_q <= 1'b1;
      end else if (seq_req_ready_i) begin
        pend_q <= 1'b0;
      end
    end
  end

  // Instruction fields and the VSETVL answer
  always_ff @(posedge clk_i) begin
    if (req_fire && is_setvl) begin
      setvl_resp_q <= vec_pkg::elem_t'(vl_clamp);
    end
    if (req_fire && !is_setvl) begin
      seq_op_o     <= acc_op_i;
      seq_vd_o     <= acc_vd_i;
      seq_vs1_o    <= acc_vs1_i;
      seq_vs2_o    <= acc_vs2_i;
      seq_scalar_o <= acc_scalar_i;
    end
  end

  assign seq_req_valid_o = pend_q;
  // vl cannot move while an instruction is held
  assign seq_vl_o        = vl_q;

  // Only one of the two answers can be live in a cycle
  assign acc_resp_valid_o = setvl_valid_q || seq_resp_valid_i;
  assign acc_resp_o       = setvl_valid_q ? setvl_resp_q : seq_resp_i;

endmodule

`default_nettype wire

/* hw/vec_core.sv */
// Vector coprocessor top level
// Dispatcher, sequencer and the row of lanes
`timescale 1ns/1ps
`default_nettype none

module vec_core (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  // Scalar core request
  input  wire logic              acc_req_valid_i,
  output logic                   acc_req_ready_o,
  input  vec_pkg::vec_op_e       acc_op_i,
  input  vec_pkg::vreg_idx_t     acc_vd_i,
  input  vec_pkg::vreg_idx_t     acc_vs1_i,
  input  vec_pkg::vreg_idx_t     acc_vs2_i,
  input  vec_pkg::elem_t         acc_scalar_i,
  // Scalar core response
  output logic                   acc_resp_valid_o,
  output vec_pkg::elem_t         acc_resp_o
);

  ////////////////////
  // Dispatcher
  ////////////////////

  logic                 seq_req_valid;
  logic                 seq_req_ready;
  vec_pkg::vec_op_e     seq_op;
  vec_pkg::vreg_idx_t   seq_vd;
  vec_pkg::vreg_idx_t   seq_vs1;
  vec_pkg::vreg_idx_t   seq_vs2;
  vec_pkg::elem_t       seq_scalar;
  vec_pkg::vl_t         seq_vl;
  logic                 seq_idle;
  logic                 seq_resp_valid;
  vec_pkg::elem_t       seq_resp;

  vec_dispatcher i_dispatcher (
    .clk_i            (clk_i           ),
    .arst_n_i         (arst_n_i        ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_op_i         (acc_op_i        ),
    .acc_vd_i         (acc_vd_i        ),
    .acc_vs1_i        (acc_vs1_i       ),
    .acc_vs2_i        (acc_vs2_i       ),
    .acc_scalar_i     (acc_scalar_i    ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_o       (acc_resp_o      ),
    .seq_req_valid_o  (seq_req_valid   ),
    .seq_req_ready_i  (seq_req_ready   ),
    .seq_op_o         (seq_op          ),
    .seq_vd_o         (seq_vd          ),
    .seq_vs1_o        (seq_vs1         ),
    .seq_vs2_o        (seq_vs2         ),
    .seq_scalar_o     (seq_scalar      ),
    .seq_vl_o         (seq_vl          ),
    .seq_idle_i       (seq_idle        ),
    .seq_resp_valid_i (seq_resp_valid  ),
    .seq_resp_i       (seq_resp        )
  );

  ////////////////////
  // Sequencer
  ////////////////////

  logic                                 pe_req_valid;
  vec_pkg::vec_op_e                     pe_op;
  vec_pkg::vreg_idx_t                   pe_vd;
  vec_pkg::vreg_idx_t                   pe_vs1;
  vec_pkg::vreg_idx_t                   pe_vs2;
  vec_pkg::elem_t                       pe_scalar;
  vec_pkg::vl_t                         pe_vl;
  logic           [vec_pkg::NrLanes-1:0] lane_done;
  vec_pkg::elem_t [vec_pkg::NrLanes-1:0] lane_scalar;

  vec_sequencer i_sequencer (
    .clk_i            (clk_i         ),
    .arst_n_i         (arst_n_i      ),
    .seq_req_valid_i  (seq_req_valid ),
    .seq_req_ready_o  (seq_req_ready ),
    .seq_op_i         (seq_op        ),
    .seq_vd_i         (seq_vd        ),
    .seq_vs1_i        (seq_vs1       ),
    .seq_vs2_i        (seq_vs2       ),
    .seq_scalar_i     (seq_scalar    ),
    .seq_vl_i         (seq_vl        ),
    .seq_idle_o       (seq_idle      ),
    .seq_resp_valid_o (seq_resp_valid),
    .seq_resp_o       (seq_resp      ),
    .pe_req_valid_o   (pe_req_valid  ),
    .pe_op_o          (pe_op         ),
    .pe_vd_o          (pe_vd         ),
    .pe_vs1_o         (pe_vs1        ),
    .pe_vs2_o         (pe_vs2        ),
    .pe_scalar_o      (pe_scalar     ),
    .pe_vl_o          (pe_vl         ),
    .lane_done_i      (lane_done     ),
    .lane_scalar_i    (lane_scalar   )
  );

  ////////////////////
  // Lanes
  ////////////////////

  for (genvar lane = 0; lane < vec_pkg::NrLanes; lane++) begin : gen_lanes
    vec_lane #(
      .LaneId (lane)
    ) i_lane (
      .clk_i          (clk_i            ),
      .arst_n_i       (arst_n_i         ),
      .pe_req_valid_i (pe_req_valid     ),
      .pe_op_i        (pe_op            ),
      .pe_vd_i        (pe_vd            ),
      .pe_vs1_i       (pe_vs1           ),
      .pe_vs2_i       (pe_vs2           ),
      .pe_scalar_i    (pe_scalar        ),
      .pe_vl_i        (pe_vl            ),
      .lane_done_o    (lane_done[lane]  ),
      .lane_scalar_o  (lane_scalar[lane])
    );
  end : gen_lanes

endmodule

`default_nettype wire

/* tb/vec_core_assert.sv */
// Concurrent checks on the core-side handshake and response rules
// Bound into the top level
`timescale 1ns/1ps
`default_nettype none

module vec_core_assert (
  input wire logic        clk_i,
  input wire logic        arst_n_i,
  input wire logic        acc_req_valid_i,
  input wire logic        acc_req_ready_o,
  input vec_pkg::vec_op_e acc_op_i,
  input wire logic        acc_resp_valid_o
);

  int unsigned fail_count = 0;
  logic        req_fire;
  logic        answer_req;
  logic        answer_pending_q;

  assign req_fire   = acc_req_valid_i && acc_req_ready_o;
  assign answer_req = req_fire && (acc_op_i inside {vec_pkg::VSETVL, vec_pkg::VEXTRACT});

  // Set by an answering request, cleared by its response
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      answer_pending_q <= 1'b0;
    end else if (answer_req) begin
      answer_pending_q <= 1'b1;
    end else if (acc_resp_valid_o) begin
      answer_pending_q <= 1'b0;
    end
  end

  ////////////////////
  // Properties
  ////////////////////

  resp_low_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !acc_resp_valid_o)
    else begin
      $error("Response valid in the first cycle after reset");
      fail_count++;
    end

  setvl_answers_next: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_fire && acc_op_i == vec_pkg::VSETVL) |=> acc_resp_valid_o)
    else begin
      $error("No response one cycle after a VSETVL transfer");
      fail_count++;
    end

  resp_only_when_asked: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    acc_resp_valid_o |-> answer_pending_q)
    else begin
      $error("Response pulse with no VSETVL or VEXTRACT outstanding");
      fail_count++;
    end

  busy_after_vector_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_fire && acc_op_i != vec_pkg::VSETVL) |=> !acc_req_ready_o)
    else begin
      $error("Ready still high the cycle after a vector instruction transfer");
      fail_count++;
    end

endmodule

bind vec_core vec_core_assert i_assert (
  .clk_i            (clk_i           ),
  .arst_n_i         (arst_n_i        ),
  .acc_req_valid_i  (acc_req_valid_i ),
  .acc_req_ready_o  (acc_req_ready_o ),
  .acc_op_i         (acc_op_i        ),
  .acc_resp_valid_o (acc_resp_valid_o)
);

`default_nettype wire

/* tb/vec_core_tb.sv */
// Testbench for the vector coprocessor
// Clock, reset, reference model, directed and random stimulus, closing report
`timescale 1ns/1ps
`default_nettype none

module vec_core_tb;

  // About 300 requests at up to 6 cycles each plus margin
  localparam int unsigned TimeoutCycles = 4000;

  logic               clk_i = 1'b0;
  logic               arst_n_i;
  logic               acc_req_valid_i;
  logic               acc_req_ready_o;
  vec_pkg::vec_op_e   acc_op_i;
  vec_pkg::vreg_idx_t acc_vd_i;
  vec_pkg::vreg_idx_t acc_vs1_i;
  vec_pkg::vreg_idx_t acc_vs2_i;
  vec_pkg::elem_t     acc_scalar_i;
  logic               acc_resp_valid_o;
  vec_pkg::elem_t     acc_resp_o;

  // Reference register file indexed by register and element
  vec_pkg::elem_t model_vrf [vec_pkg::NrVRegs][vec_pkg::Vlmax];
  int unsigned    model_vl;
  logic [31:0]    rng_state = 32'd91;
  int unsigned    cycles    = 0;
  int unsigned    checks    = 0;
  int unsigned    errors    = 0;

  vec_pkg::vec_op_e vv_ops [5] = '{vec_pkg::VADD_VV, vec_pkg::VSUB_VV, vec_pkg::VAND_VV,
                                   vec_pkg::VOR_VV, vec_pkg::VXOR_VV};
  vec_pkg::vec_op_e vx_ops [6] = '{vec_pkg::VADD_VX, vec_pkg::VSUB_VX, vec_pkg::VAND_VX,
                                   vec_pkg::VOR_VX, vec_pkg::VXOR_VX, vec_pkg::VMV_VX};
  int unsigned      tail_lengths [4] = '{0, 1, 3, 5};

  vec_core dut0 (
    .clk_i            (clk_i           ),
    .arst_n_i         (arst_n_i        ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_op_i         (acc_op_i        ),
    .acc_vd_i         (acc_vd_i        ),
    .acc_vs1_i        (acc_vs1_i       ),
    .acc_vs2_i        (acc_vs2_i       ),
    .acc_scalar_i     (acc_scalar_i    ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_o       (acc_resp_o      )
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////
  // Model and helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic vec_pkg::elem_t rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // One element result from the vs2 element a and the operand b
  function automatic vec_pkg::elem_t elem_result(input vec_pkg::vec_op_e op,
                                                 input vec_pkg::elem_t a,
                                                 input vec_pkg::elem_t b);
    case (op)
      vec_pkg::VADD_VV, vec_pkg::VADD_VX: return a + b;
      vec_pkg::VSUB_VV, vec_pkg::VSUB_VX: return a - b;
      vec_pkg::VAND_VV, vec_pkg::VAND_VX: return a & b;
      vec_pkg::VOR_VV, vec_pkg::VOR_VX:   return a | b;
      vec_pkg::VXOR_VV, vec_pkg::VXOR_VX: return a ^ b;
      vec_pkg::VMV_VX:                    return b;
      default:                            return a;
    endcase
  endfunction

  // Writes body elements below vl only
  task automatic update_model(input vec_pkg::vec_op_e op, input int vd, input int vs1,
                              input int vs2, input vec_pkg::elem_t scalar);
    logic           use_scalar;
    vec_pkg::elem_t b;
    use_scalar = op inside {vec_pkg::VADD_VX, vec_pkg::VSUB_VX, vec_pkg::VAND_VX,
                            vec_pkg::VOR_VX, vec_pkg::VXOR_VX, vec_pkg::VMV_VX};
    for (int i = 0; i < int'(model_vl); i++) begin
      b = use_scalar ? scalar : model_vrf[vs1][i];
      model_vrf[vd][i] = elem_result(op, model_vrf[vs2][i], b);
    end
  endtask

  task automatic compare_value(input vec_pkg::elem_t got, input vec_pkg::elem_t exp,
                               input string what);
    checks++;
    assert (got == exp) else begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Holds valid until ready and returns 1 ns after the transfer edge
  task automatic send_request(input vec_pkg::vec_op_e op, input int vd, input int vs1,
                              input int vs2, input vec_pkg::elem_t scalar);
    acc_req_valid_i = 1'b1;
    acc_op_i        = op;
    acc_vd_i        = vec_pkg::vreg_idx_t'(vd);
    acc_vs1_i       = vec_pkg::vreg_idx_t'(vs1);
    acc_vs2_i       = vec_pkg::vreg_idx_t'(vs2);
    acc_scalar_i    = scalar;
    while (!acc_req_ready_o) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
    acc_req_valid_i = 1'b0;
    if (op != vec_pkg::VSETVL && op != vec_pkg::VEXTRACT) begin
      update_model(op, vd, vs1, vs2, scalar);
    end
  endtask

  task automatic set_length(input vec_pkg::elem_t req);
    vec_pkg::elem_t exp;
    exp = (req > vec_pkg::Vlmax) ? vec_pkg::elem_t'(vec_pkg::Vlmax) : req;
    send_request(vec_pkg::VSETVL, 0, 0, 0, req);
    // Answer is due one cycle after the transfer
    compare_value(vec_pkg::elem_t'(acc_resp_valid_o), 32'd1, "VSETVL response valid");
    compare_value(acc_resp_o, exp, "VSETVL length");
    model_vl = int'(exp);
  endtask

  task automatic read_element(input int vreg, input int idx);
    send_request(vec_pkg::VEXTRACT, 0, 0, vreg, vec_pkg::elem_t'(idx));
    while (!acc_resp_valid_o) begin
      @(posedge clk_i);
      #1;
    end
    compare_value(acc_resp_o, model_vrf[vreg][idx], $sformatf("VEXTRACT v%0d[%0d]", vreg, idx));
  endtask

  task automatic verify_register(input int vreg);
    for (int i = 0; i < int'(vec_pkg::Vlmax); i++) begin
      read_element(vreg, i);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    vec_pkg::elem_t pick;
    vec_pkg::elem_t req;
    vec_pkg::elem_t s;
    int unsigned    assert_fails;
    arst_n_i        = 1'b0;
    acc_req_valid_i = 1'b0;
    acc_op_i        = vec_pkg::VSETVL;
    acc_vd_i        = '0;
    acc_vs1_i       = '0;
    acc_vs2_i       = '0;
    acc_scalar_i    = '0;
    for (int r = 0; r < int'(vec_pkg::NrVRegs); r++) begin
      for (int i = 0; i < int'(vec_pkg::Vlmax); i++) begin
        model_vrf[r][i] = '0;
      end
    end
    model_vl = vec_pkg::Vlmax;
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    // Reset state
    compare_value(vec_pkg::elem_t'(acc_req_ready_o), 32'd1, "ready after reset");
    for (int r = 0; r < int'(vec_pkg::NrVRegs); r++) begin
      verify_register(r);
    end
    set_length(32'd15);

    // Length clamping with small and full-range requests
    repeat (12) begin
      pick = rand_word();
      req  = ((pick & 32'd1) != 0) ? rand_word() % 32'd16 : rand_word();
      set_length(req);
    end
    set_length(vec_pkg::elem_t'(vec_pkg::Vlmax));

    // Large sources so add wraps in the upper elements
    send_request(vec_pkg::VMV_VX, 1, 0, 0, rand_word() | 32'h8000_0000);
    send_request(vec_pkg::VMV_VX, 2, 0, 0, rand_word() | 32'h8000_0000);
    // Low elements of v1 above those of v2 so sub wraps there
    set_length(32'd5);
    send_request(vec_pkg::VMV_VX, 1, 0, 0, rand_word() | 32'h8000_0000);
    set_length(32'd2);
    send_request(vec_pkg::VMV_VX, 2, 0, 0, rand_word() & 32'h7fff_ffff);
    set_length(vec_pkg::elem_t'(vec_pkg::Vlmax));
    verify_register(1);
    verify_register(2);
    foreach (vv_ops[k]) begin
      send_request(vv_ops[k], 3 + k, 1, 2, '0);
      verify_register(3 + k);
    end

    // Vector-scalar ops with VSUB_VX working in place on v3
    foreach (vx_ops[k]) begin
      send_request(vx_ops[k], 2 + k, 0, 3, rand_word());
      verify_register(2 + k);
    end

    // Tail undisturbed
    foreach (tail_lengths[k]) begin
      set_length(vec_pkg::elem_t'(tail_lengths[k]));
      send_request(vec_pkg::VADD_VV, 6, 1, 3, '0);
      send_request(vec_pkg::VMV_VX, 7, 0, 0, rand_word());
      verify_register(6);
      verify_register(7);
    end

    // Back-to-back chain on v5 where a repeated step changes the result
    set_length(vec_pkg::elem_t'(vec_pkg::Vlmax));
    s = rand_word();
    send_request(vec_pkg::VXOR_VX, 5, 0, 3, s);
    send_request(vec_pkg::VADD_VV, 5, 1, 5, '0);
    send_request(vec_pkg::VSUB_VX, 5, 0, 5, rand_word());
    verify_register(5);

    assert_fails = dut0.i_assert.fail_count;
    $display("Done: %0d checks, %0d check errors, %0d assertion failures",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
common/vec_pkg.sv
hw/lane/vec_vrf.sv
hw/lane/vec_lane.sv
hw/vec_sequencer.sv
hw/vec_dispatcher.sv
hw/vec_core.sv
tb/vec_core_assert.sv
tb/vec_core_tb.sv

/* Makefile */
TOP := vec_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f list.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^TESTBENCH PASSED$$" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir sim.log
